/* hw/psgPkg.sv */
`default_nettype none

// ==================================================
// sound-side constants
// ==================================================
package psgPkg;

	// wave-table channels sharing the wave bus
	localparam int NumChan = 8;
	localparam int ChanIdxW = 3;

	// signed wave sample
	localparam int SampleW = 12;

	// phase accumulator, top bits select the sample within the wave
	localparam int PhaseW = 24;
	localparam int FreqW = 16;

	// sample width plus three bits of headroom for eight channels
	localparam int MixW = 15;

endpackage

`default_nettype wire

/* hw/waveBusPkg.sv */
`default_nettype none

// ==================================================
// wave-memory bus constants
// ==================================================
package waveBusPkg;

	localparam int WaveAddrW = 11;
	localparam int WaveDataW = 12;
	localparam int WaveDepth = 2048;

	// one wave is 256 words, the base selects which wave
	localparam int WaveIdxW = 8;
	localparam int WaveBaseW = WaveAddrW - WaveIdxW;

endpackage

`default_nettype wire

/* hw/psgBusArb.sv */
`default_nettype none

// fixed-priority arbiter for the wave bus, lowest index wins
module psgBusArb import psgPkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                ce,
	input  logic                ack,
	input  logic [NumChan-1:0]  req,
	output logic [NumChan-1:0]  sel,
	output logic [ChanIdxW-1:0] seln
);

	logic [ChanIdxW-1:0] pickIdx;
	logic                anyReq;
	logic                decide;

	assign anyReq = |req;

	// the owner may only change on an enabled edge with the bus free
	assign decide = ce && ack && anyReq;

	// ==================================================
	// priority encoder
	// ==================================================
	// scanning downward leaves the lowest requester in pickIdx
	always_comb begin
		pickIdx = '0;
		for (int i = NumChan - 1; i >= 0; i--) begin
			if (req[i]) begin
				pickIdx = ChanIdxW'(i);
			end
		end
	end

	// ==================================================
	// grant register
	// ==================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (decide) begin
			sel <= NumChan'(1) << pickIdx;
			seln <= pickIdx;
		end
		// no request keeps the last owner parked on the bus
	end

endmodule

`default_nettype wire

/* hw/psgWaveChannel.sv */
`default_nettype none

// one wave-table channel: phase stepping, fetch request and sample latch
module psgWaveChannel import psgPkg::*, waveBusPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ce,
	input  logic                 regWe,
	input  logic [FreqW-1:0]     freq,
	input  logic [WaveBaseW-1:0] base,
	input  logic                 en,
	input  logic                 sel,
	input  logic                 ack,
	input  logic [SampleW-1:0]   rdData,
	output logic                 req,
	output logic [WaveAddrW-1:0] fetchAddr,
	output logic [SampleW-1:0]   sample,
	output logic                 enabled
);

	logic [FreqW-1:0]     freqR;
	logic [WaveBaseW-1:0] baseR;
	logic [PhaseW-1:0]    phase;
	logic [PhaseW-1:0]    phaseNext;
	logic                 step;
	logic                 idxChange;
	logic                 served;

	// ==================================================
	// phase accumulator
	// ==================================================
	assign phaseNext = phase + PhaseW'(freqR);
	assign step = ce && enabled;
	assign idxChange = phaseNext[PhaseW-1 -: WaveIdxW] != phase[PhaseW-1 -: WaveIdxW];

	always_ff @(posedge clk) begin
		if (rst) begin
			freqR <= '0;
			baseR <= '0;
			enabled <= 1'b0;
			phase <= '0;
		end else if (regWe) begin
			// a register write restarts the wave from its first sample
			freqR <= freq;
			baseR <= base;
			enabled <= en;
			phase <= '0;
		end else if (step) begin
			phase <= phaseNext;
		end
	end

	// address of the sample the phase currently points at
	assign fetchAddr = {baseR, phase[PhaseW-1 -: WaveIdxW]};

	// ==================================================
	// fetch request and sample latch
	// ==================================================
	// req guards the latch, ack alone is also high while the bus idles
	assign served = sel && ack && req;

	always_ff @(posedge clk) begin
		if (rst) begin
			req <= 1'b0;
		end else if (step && idxChange) begin
			// a fresh index always asks again, a pending request stays single
			req <= 1'b1;
		end else if (served) begin
			req <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sample <= '0;
		end else if (served) begin
			sample <= rdData;
		end
	end

endmodule

`default_nettype wire

/* hw/waveBusMaster.sv */
`default_nettype none

// runs one wave RAM read for the current bus owner
module waveBusMaster import psgPkg::*, waveBusPkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [NumChan-1:0]           sel,
	input  logic [NumChan-1:0]           req,
	input  logic [ChanIdxW-1:0]          seln,
	input  logic [NumChan*WaveAddrW-1:0] addrs,
	output logic                         rdEn,
	output logic [WaveAddrW-1:0]         rdAddr,
	output logic                         ack
);

	// high in the cycle the RAM output is valid
	logic waiting;
	logic start;

	// ==================================================
	// sequencer
	// ==================================================
	// a read starts when the bus is idle and the owner still wants data
	assign start = !waiting && |(sel & req);

	always_ff @(posedge clk) begin
		if (rst) begin
			waiting <= 1'b0;
		end else begin
			waiting <= start;
		end
	end

	// launch cycle drops ack so nobody re-arbitrates or latches early
	assign ack = waiting || !start;

	// ==================================================
	// read port drive
	// ==================================================
	assign rdEn = start;
	assign rdAddr = addrs[seln*WaveAddrW +: WaveAddrW];

endmodule

`default_nettype wire

/* hw/waveTableRam.sv */
`default_nettype none

// wave sample storage, host writes and bus reads on one clock
module waveTableRam import waveBusPkg::*; (
	input  logic                 clk,
	input  logic                 we,
	input  logic [WaveAddrW-1:0] wAddr,
	input  logic [WaveDataW-1:0] wData,
	input  logic                 rdEn,
	input  logic [WaveAddrW-1:0] rdAddr,
	output logic [WaveDataW-1:0] rdData
);

	logic [WaveDataW-1:0] mem [WaveDepth];

	// host load port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wAddr] <= wData;
		end
	end

	// registered read, output holds between reads
	always_ff @(posedge clk) begin
		if (rdEn) begin
			rdData <= mem[rdAddr];
		end
	end

endmodule

`default_nettype wire

/* hw/psgMixer.sv */
`default_nettype none

// sums the samples of the enabled channels
module psgMixer import psgPkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [NumChan*SampleW-1:0] samples,
	input  logic [NumChan-1:0]         en,
	output logic [MixW-1:0]            mixOut
);

	logic signed [MixW-1:0] sum;

	// signed add with sign extension, disabled channels add nothing
	always_comb begin
		sum = '0;
		for (int i = 0; i < NumChan; i++) begin
			if (en[i]) begin
				sum = sum + MixW'($signed(samples[i*SampleW +: SampleW]));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mixOut <= '0;
		end else begin
			mixOut <= sum;
		end
	end

endmodule

`default_nettype wire

/* hw/psgWaveFetch.sv */
`default_nettype none

// wave-table fetch path: channels, bus arbiter, bus master, wave RAM, mixer
module psgWaveFetch import psgPkg::*, waveBusPkg::*; (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 ce,
	input  logic                 ramWe,
	input  logic [WaveAddrW-1:0] ramAddr,
	input  logic [WaveDataW-1:0] ramData,
	input  logic                 chanWe,
	input  logic [ChanIdxW-1:0]  chanSel,
	input  logic [FreqW-1:0]     chanFreq,
	input  logic [WaveBaseW-1:0] chanBase,
	input  logic                 chanEn,
	output logic [NumChan-1:0]   busGrant,
	output logic [ChanIdxW-1:0]  busOwner,
	output logic [MixW-1:0]      mixOut
);

	logic [NumChan-1:0]           req;
	logic [NumChan-1:0]           sel;
	logic [ChanIdxW-1:0]          seln;
	logic                         ack;
	logic                         rdEn;
	logic [WaveAddrW-1:0]         rdAddr;
	logic [WaveDataW-1:0]         rdData;
	logic [NumChan*WaveAddrW-1:0] addrs;
	logic [NumChan*SampleW-1:0]   samples;
	logic [NumChan-1:0]           enabled;

	// ==================================================
	// channels
	// ==================================================
	for (genvar i = 0; i < NumChan; i++) begin : gChan
		logic regWe;

		// host strobe steered to the addressed channel
		assign regWe = chanWe && (chanSel == ChanIdxW'(i));

		psgWaveChannel chan (
			.clk       (clk),
			.rst       (rst),
			.ce        (ce),
			.regWe     (regWe),
			.freq      (chanFreq),
			.base      (chanBase),
			.en        (chanEn),
			.sel       (sel[i]),
			.ack       (ack),
			.rdData    (rdData),
			.req       (req[i]),
			.fetchAddr (addrs[i*WaveAddrW +: WaveAddrW]),
			.sample    (samples[i*SampleW +: SampleW]),
			.enabled   (enabled[i])
		);
	end

	// ==================================================
	// wave bus
	// ==================================================
	psgBusArb arb0 (
		.clk  (clk),
		.rst  (rst),
		.ce   (ce),
		.ack  (ack),
		.req  (req),
		.sel  (sel),
		.seln (seln)
	);

	waveBusMaster master0 (
		.clk    (clk),
		.rst    (rst),
		.sel    (sel),
		.req    (req),
		.seln   (seln),
		.addrs  (addrs),
		.rdEn   (rdEn),
		.rdAddr (rdAddr),
		.ack    (ack)
	);

	waveTableRam ram0 (
		.clk    (clk),
		.we     (ramWe),
		.wAddr  (ramAddr),
		.wData  (ramData),
		.rdEn   (rdEn),
		.rdAddr (rdAddr),
		.rdData (rdData)
	);

	psgMixer mixer0 (
		.clk     (clk),
		.rst     (rst),
		.samples (samples),
		.en      (enabled),
		.mixOut  (mixOut)
	);

	assign busGrant = sel;
	assign busOwner = seln;

endmodule

`default_nettype wire

/* testbench/tbChecks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==================================================
// error counters, one per check
// ==================================================
int errQuiet = 0;
int errForm = 0;
int errHold = 0;
int errOrder = 0;
int errMix = 0;
int errIdle = 0;

// ==================================================
// bus grant properties
// ==================================================
// nothing is granted while ce runs but no request has risen yet
quietBus: assert property (@(posedge clk) disable iff (rst)
	quietOn |-> (busGrant == '0 && busOwner == '0))
	else begin
		errQuiet++;
		$display("Error at %0t: busGrant = %b, expected 0; busOwner = %0d, expected 0",
			$time, $sampled(busGrant), $sampled(busOwner));
	end

grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(busGrant))
	else begin
		errForm++;
		$display("Error at %0t: busGrant = %b has more than one bit set",
			$time, $sampled(busGrant));
	end

// the set bit of the grant sits at the owner index
grantMatchesOwner: assert property (@(posedge clk) disable iff (rst)
	(busGrant != '0) |-> (busGrant == (NumChan'(1) << busOwner)))
	else begin
		errForm++;
		$display("Error at %0t: busGrant = %b, expected %b for busOwner %0d",
			$time, $sampled(busGrant), NumChan'(1) << $sampled(busOwner),
			$sampled(busOwner));
	end

// prevCe is the ce the arbiter saw on the edge just passed
holdGrant: assert property (@(posedge clk) disable iff (rst)
	!prevCe |-> (busGrant == prevGrant))
	else begin
		errHold++;
		$display("Error at %0t: busGrant = %b, expected %b without ce",
			$time, $sampled(busGrant), $sampled(prevGrant));
	end

holdOwner: assert property (@(posedge clk) disable iff (rst)
	!prevCe |-> (busOwner == prevOwner))
	else begin
		errHold++;
		$display("Error at %0t: busOwner = %0d, expected %0d without ce",
			$time, $sampled(busOwner), $sampled(prevOwner));
	end

idleNeverOwns: assert property (@(posedge clk) disable iff (rst)
	idleWatch |-> !(busGrant != '0 && busOwner == ChanIdxW'(IdleChan)))
	else begin
		errIdle++;
		$display("Error at %0t: channel %0d with zero step was granted the bus",
			$time, IdleChan);
	end

// ==================================================
// mixer properties
// ==================================================
silentMix: assert property (@(posedge clk) disable iff (rst)
	mixZero |-> (mixOut == '0))
	else begin
		errMix++;
		$display("Error at %0t: mixOut = %0d, expected 0",
			$time, $signed($sampled(mixOut)));
	end

mixValue: assert property (@(posedge clk) disable iff (rst)
	mixCheck |-> (mixOut == expMix))
	else begin
		errMix++;
		$display("Error at %0t: mixOut = %0d, expected %0d",
			$time, $signed($sampled(mixOut)), $signed($sampled(expMix)));
	end

// first appearances of the owners against the lowest-first order
task automatic checkOwnerOrder();
	for (int i = 0; i < 4; i++) begin
		assert (ownerOrder[i] == burstChan[i]) else begin
			errOrder++;
			$display("Error at %0t: busOwner #%0d = %0d, expected %0d",
				$time, i, ownerOrder[i], burstChan[i]);
		end
	end
endtask

`endif

/* testbench/tbPsgWaveFetch.sv */
`default_nettype none

module tbPsgWaveFetch import psgPkg::*, waveBusPkg::*; ();

	// reset, RAM fill, first round and two hold phases come to about 2600
	localparam int TimeoutCycles = 4000;
	localparam int HoldCycles = 200;
	localparam int IdleChan = 1;
	localparam logic [FreqW-1:0] StepFreq = 16'h1000;
	// a step of 16'h1000 moves the sample index once every 16 ce
	localparam int FirstReqCe = 16;

	logic                 clk = 1'b0;
	logic                 rst = 1'b1;
	logic                 ce = 1'b0;
	logic                 ramWe = 1'b0;
	logic [WaveAddrW-1:0] ramAddr = '0;
	logic [WaveDataW-1:0] ramData = '0;
	logic                 chanWe = 1'b0;
	logic [ChanIdxW-1:0]  chanSel = '0;
	logic [FreqW-1:0]     chanFreq = '0;
	logic [WaveBaseW-1:0] chanBase = '0;
	logic                 chanEn = 1'b0;
	logic [NumChan-1:0]   busGrant;
	logic [ChanIdxW-1:0]  busOwner;
	logic [MixW-1:0]      mixOut;

	// ce pacing
	logic       ceRun = 1'b0;
	logic [1:0] ceDiv = '0;
	logic [1:0] stretch = '0;

	// scoreboard state
	logic                quietOn = 1'b1;
	logic                mixZero = 1'b1;
	logic                idleWatch = 1'b0;
	logic                mixCheck = 1'b0;
	logic [MixW-1:0]     expMix = '0;
	logic                prevCe = 1'b0;
	logic [NumChan-1:0]  prevGrant = '0;
	logic [ChanIdxW-1:0] prevOwner = '0;
	logic [NumChan-1:0]  ownerSeen = '0;
	int                  ownerOrder[$];
	int                  burstChan[4] = '{0, 2, 5, 7};
	logic [FreqW-1:0]    chanStep[NumChan] = '{default: '0};
	logic [NumChan-1:0]  chanOn = '0;
	int                  cycles = 0;
	int                  ceSeen = 0;

	`include "tbChecks.svh"

	psgWaveFetch dut0 (
		.clk      (clk),
		.rst      (rst),
		.ce       (ce),
		.ramWe    (ramWe),
		.ramAddr  (ramAddr),
		.ramData  (ramData),
		.chanWe   (chanWe),
		.chanSel  (chanSel),
		.chanFreq (chanFreq),
		.chanBase (chanBase),
		.chanEn   (chanEn),
		.busGrant (busGrant),
		.busOwner (busOwner),
		.mixOut   (mixOut)
	);

	always #5 clk = ~clk;

	// ==================================================
	// ce: one cycle in four, now and then a short run of extra cycles
	// ==================================================
	always @(posedge clk) begin
		if (!ceRun) begin
			ce <= 1'b0;
			ceDiv <= '0;
			stretch <= '0;
		end else begin
			ceDiv <= ceDiv + 2'd1;
			if (stretch != '0) begin
				ce <= 1'b1;
				stretch <= stretch - 2'd1;
			end else begin
				ce <= (ceDiv == 2'd3);
				if (ceDiv == 2'd3 && ($urandom % 4) == 0) begin
					stretch <= 2'($urandom % 4);
				end
			end
		end
	end

	always @(posedge clk) begin
		prevCe <= ce;
		prevGrant <= busGrant;
		prevOwner <= busOwner;
		cycles <= cycles + 1;
		// requests rise on the FirstReqCe-th ce, a grant needs one more
		if (ce) begin
			ceSeen <= ceSeen + 1;
			if (ceSeen == FirstReqCe) begin
				quietOn <= 1'b0;
			end
		end
		if (cycles == TimeoutCycles) begin
			$display("Timeout: the test did not end within %0d cycles", TimeoutCycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// owners in order of first appearance
	always @(negedge clk) begin
		if (!rst && busGrant != '0) begin
			mixZero <= 1'b0;
			if (!ownerSeen[busOwner]) begin
				ownerSeen[busOwner] = 1'b1;
				ownerOrder.push_back(int'(busOwner));
			end
		end
	end

	// region k holds 16k+5, negative for odd k
	function automatic int fillInt(int k);
		return (k % 2 == 1) ? -(16 * k + 5) : 16 * k + 5;
	endfunction

	function automatic logic [MixW-1:0] expectedMix();
		int sum = 0;
		for (int k = 0; k < NumChan; k++) begin
			// a channel that never steps keeps its zero reset sample
			if (chanOn[k] && chanStep[k] != '0) begin
				sum += fillInt(k);
			end
		end
		return MixW'(sum);
	endfunction

	task automatic fillRam();
		for (int a = 0; a < WaveDepth; a++) begin
			@(posedge clk);
			ramWe <= 1'b1;
			ramAddr <= WaveAddrW'(a);
			ramData <= WaveDataW'(fillInt(a >> WaveIdxW));
		end
		@(posedge clk);
		ramWe <= 1'b0;
	endtask

	task automatic writeChan(int k, logic [FreqW-1:0] f, logic e);
		@(posedge clk);
		chanWe <= 1'b1;
		chanSel <= ChanIdxW'(k);
		chanFreq <= f;
		chanBase <= WaveBaseW'(k);
		chanEn <= e;
		chanStep[k] = f;
		chanOn[k] = e;
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		int totalErr;
		void'($urandom(32'hbdc8_d2ff));
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		fillRam();

		// burst with ce held low so all phases start together
		idleWatch <= 1'b1;
		writeChan(IdleChan, '0, 1'b1);
		foreach (burstChan[i]) begin
			writeChan(burstChan[i], StepFreq, 1'b1);
		end
		@(posedge clk);
		chanWe <= 1'b0;
		ceRun <= 1'b1;

		while (ownerOrder.size() < 4) begin
			@(posedge clk);
		end
		checkOwnerOrder();

		// grant to latch is two cycles, the mixer adds one
		repeat (4) @(posedge clk);
		expMix <= expectedMix();
		mixCheck <= 1'b1;
		repeat (HoldCycles) @(posedge clk);

		// mixOut loses channel 5 one cycle after its enable drops
		writeChan(5, StepFreq, 1'b0);
		@(posedge clk);
		chanWe <= 1'b0;
		@(posedge clk);
		expMix <= expectedMix();
		repeat (HoldCycles) @(posedge clk);

		totalErr = errQuiet + errForm + errHold + errOrder + errMix + errIdle;
		$display("errors: quiet %0d, grant form %0d, hold %0d, order %0d, mix %0d, idle %0d",
			errQuiet, errForm, errHold, errOrder, errMix, errIdle);
		if (totalErr == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+testbench
hw/psgPkg.sv
hw/waveBusPkg.sv
hw/psgBusArb.sv
hw/psgWaveChannel.sv
hw/waveBusMaster.sv
hw/waveTableRam.sv
hw/psgMixer.sv
hw/psgWaveFetch.sv
testbench/tbPsgWaveFetch.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbPsgWaveFetch -f files.f -o simPsgWaveFetch \
	&& ./obj_dir/simPsgWaveFetch | tee /dev/stderr \
		| grep -q "Simulation completed successfully" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
